// File: logic/buffer_cfg.svh
`ifndef BUFFER_CFG_SVH
`define BUFFER_CFG_SVH

// virtual channels sharing one input port
// keep at two or more, the vc number needs at least one bit
`define VC_NUM 4

// flits per vc slice
// must be a power of two and at least two, pointers wrap by overflow
`define VC_DEPTH 4

// payload bits of one flit
// header and tail flags are stored on top of these
`define PAYLOAD_W 32

// upstream credits per vc equal the slice depth
// the vc field of the incoming flit is not stored,
// the vc arrives on its own select port

`endif

// File: logic/buffer_pkg.sv
`include "buffer_cfg.svh"

package buffer_pkg;

    // field widths derived from the config macros
    localparam int VC_IDX_W = $clog2(`VC_NUM);
    localparam int SLOT_W = $clog2(`VC_DEPTH);
    localparam int DEPTH_W = $clog2(`VC_DEPTH + 1); // holds 0 up to a full slice

    // {header flag, tail flag, payload}
    typedef logic [`PAYLOAD_W+1:0] flit_t;

    // one-hot select or per-vc status
    typedef logic [`VC_NUM-1:0] vc_mask_t;

    typedef logic [VC_IDX_W-1:0] vc_idx_t; // binary vc number
    typedef logic [SLOT_W-1:0] slot_t; // position inside a slice

    // vc number over slot, slices sit back to back in memory
    typedef logic [VC_IDX_W+SLOT_W-1:0] ram_addr_t;

    // per-vc occupancy
    typedef logic [DEPTH_W-1:0] depth_t;

endpackage

// File: logic/flit_ram.sv
`include "buffer_cfg.svh"

// shared flit memory, one write and one read port
// read data is registered, one cycle of latency
module flit_ram (
    input  logic                  clk,
    input  logic                  reset,

    input  buffer_pkg::flit_t     din,
    input  logic                  wr_en,
    input  buffer_pkg::ram_addr_t wr_addr,

    input  logic                  rd_en,
    input  buffer_pkg::ram_addr_t rd_addr,
    output buffer_pkg::flit_t     dout
);

    import buffer_pkg::*;

    // VC_NUM slices of VC_DEPTH flits each
    flit_t mem [`VC_NUM*`VC_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= din;
        end
    end

    // read port
    // on a same-address read/write the old flit comes out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dout <= '0;
        end else if (rd_en) begin
            dout <= mem[rd_addr];
        end
        // no read, dout keeps the last flit
    end

endmodule

// File: logic/vc_ptr_bank.sv
`include "buffer_cfg.svh"

// per-vc read/write pointers and occupancy
// steers the shared flit memory through wr_addr / rd_addr
module vc_ptr_bank (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wr_en,
    input  buffer_pkg::vc_mask_t  vc_num_wr,
    input  logic                  rd_en,
    input  buffer_pkg::vc_mask_t  vc_num_rd,

    output buffer_pkg::ram_addr_t wr_addr,
    output buffer_pkg::ram_addr_t rd_addr,
    output buffer_pkg::vc_mask_t  vc_not_empty
);

    import buffer_pkg::*;

    // pointer and depth of every vc
    slot_t  [`VC_NUM-1:0] wr_ptr;
    slot_t  [`VC_NUM-1:0] rd_ptr;
    depth_t [`VC_NUM-1:0] depth;

    // strobes qualified by the one-hot selects
    vc_mask_t wr_vc;
    vc_mask_t rd_vc;

    // selected vc number and slot
    vc_idx_t wr_idx;
    vc_idx_t rd_idx;
    slot_t   wr_slot;
    slot_t   rd_slot;

    // one-hot to binary, OR of the set bit positions
    function automatic vc_idx_t onehot_to_idx(input vc_mask_t sel);
        vc_idx_t idx;
        idx = '0;
        for (int i = 0; i < `VC_NUM; i++) begin
            if (sel[i]) begin
                idx = idx | vc_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // one-hot mux over the per-vc pointers
    function automatic slot_t pick_slot(
        input vc_mask_t             sel,
        input slot_t [`VC_NUM-1:0] ptrs
    );
        slot_t slot;
        slot = '0;
        for (int i = 0; i < `VC_NUM; i++) begin
            if (sel[i]) begin
                slot = slot | ptrs[i];
            end
        end
        return slot;
    endfunction

    assign wr_vc = wr_en ? vc_num_wr : '0;
    assign rd_vc = rd_en ? vc_num_rd : '0;

    // address selection
    // valid in the strobe cycle, the memory ignores it without a strobe
    assign wr_idx  = onehot_to_idx(vc_num_wr);
    assign rd_idx  = onehot_to_idx(vc_num_rd);
    assign wr_slot = pick_slot(vc_num_wr, wr_ptr);
    assign rd_slot = pick_slot(vc_num_rd, rd_ptr);

    assign wr_addr = {wr_idx, wr_slot}; // slice base is the vc number
    assign rd_addr = {rd_idx, rd_slot};

    genvar g;
    generate
        for (g = 0; g < `VC_NUM; g++) begin : g_vc

            // write pointer, wraps inside the slice by overflow
            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    wr_ptr[g] <= '0;
                end else if (wr_vc[g]) begin
                    wr_ptr[g] <= wr_ptr[g] + 1'b1;
                end
            end

            // read pointer
            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    rd_ptr[g] <= '0;
                end else if (rd_vc[g]) begin
                    rd_ptr[g] <= rd_ptr[g] + 1'b1;
                end
            end

            // occupancy, holds when read and write hit the same vc
            always_ff @(posedge clk or posedge reset) begin
                if (reset) begin
                    depth[g] <= '0;
                end else if (wr_vc[g] && !rd_vc[g]) begin
                    depth[g] <= depth[g] + 1'b1;
                end else if (!wr_vc[g] && rd_vc[g]) begin
                    depth[g] <= depth[g] - 1'b1;
                end
            end

            assign vc_not_empty[g] = (depth[g] != '0);

        end
    endgenerate

    // a full slice has wr_ptr == rd_ptr with depth == VC_DEPTH
    // a read and write to that vc in one cycle still return the oldest
    // flit, since the memory samples before the write lands

endmodule

// File: logic/vc_buffer.sv
`include "buffer_cfg.svh"

// vc input buffer of one router port
// all vcs share a single flit memory, each vc owns a fixed slice of it
module vc_buffer (
    input  logic                 clk,
    input  logic                 reset,

    // write side, from the upstream link
    input  buffer_pkg::flit_t    din,
    input  logic                 wr_en,
    input  buffer_pkg::vc_mask_t vc_num_wr,    // one-hot

    // read side, from switch allocation
    input  logic                 rd_en,
    input  buffer_pkg::vc_mask_t vc_num_rd,    // one-hot

    output buffer_pkg::flit_t    dout,         // valid one cycle after a read
    output buffer_pkg::vc_mask_t vc_not_empty
);

    import buffer_pkg::*;

    // memory addresses formed by the pointer bank
    ram_addr_t wr_addr;
    ram_addr_t rd_addr;

    // pointer and depth bookkeeping per vc
    // the addresses are combinational, so the memory
    // sees them in the same cycle as the strobes
    vc_ptr_bank u_ptr_bank (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // shared flit storage with registered read port
    // dout holds its value until the next read
    flit_ram u_flit_ram (
        .clk     (clk),
        .reset   (reset),
        .din     (din),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .dout    (dout)
    );

    // flow control notes
    // the buffer never stalls and never drops a flit
    // upstream credits keep each vc at or below VC_DEPTH flits
    // reads only go to vcs shown non-empty before the edge
    // a read and write to one vc in the same cycle need that vc non-empty

endmodule

// File: test/vc_buffer_model.svh
`ifndef VC_BUFFER_MODEL_SVH
`define VC_BUFFER_MODEL_SVH

// reference queues, oldest flit at the front
flit_t       model_q [`VC_NUM][$];
flit_t       expect_dout;   // last flit read, held on dout
logic [31:0] rng_state;

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic int rand_below(input int n);
    return int'(xorshift32() % unsigned'(n));
endfunction

// header and tail flags land in the top bits
function automatic flit_t random_flit();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = xorshift32();
    hi = xorshift32();
    return flit_t'({hi, lo});
endfunction

// random start, first vc with room for a flit, -1 if none
function automatic int pick_open_vc();
    int start;
    int vc;
    start = rand_below(`VC_NUM);
    for (int k = 0; k < `VC_NUM; k++) begin
        vc = (start + k) % `VC_NUM;
        if (model_q[vc].size() < `VC_DEPTH) return vc;
    end
    return -1;
endfunction

// same walk, first vc holding a flit
function automatic int pick_busy_vc();
    int start;
    int vc;
    start = rand_below(`VC_NUM);
    for (int k = 0; k < `VC_NUM; k++) begin
        vc = (start + k) % `VC_NUM;
        if (model_q[vc].size() > 0) return vc;
    end
    return -1;
endfunction

function automatic vc_mask_t model_mask();
    vc_mask_t m;
    m = '0;
    for (int i = 0; i < `VC_NUM; i++) begin
        m[i] = (model_q[i].size() != 0);
    end
    return m;
endfunction

`endif

// File: test/vc_buffer_tb.sv
`include "buffer_cfg.svh"

module vc_buffer_tb;

    import buffer_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam logic [31:0] SEED = 32'd69619;
    localparam int SINGLE_OPS = 80;
    localparam int WRAP_ROUNDS = 6;
    localparam int RANDOM_OPS = 3000;
    localparam int WRAP_VC = `VC_NUM - 1;

    // cycles of every phase plus a margin in time units
    localparam int TOTAL_CYCLES = 3 + SINGLE_OPS + `VC_DEPTH + `VC_NUM
        + WRAP_ROUNDS * (2 * `VC_DEPTH + 4) + RANDOM_OPS + 2 * `VC_NUM * `VC_DEPTH
        + `VC_NUM + 8;
    localparam int TIMEOUT = (TOTAL_CYCLES + 200) * CLK_PERIOD;

    logic     clk;
    logic     reset;
    flit_t    din;
    logic     wr_en;
    vc_mask_t vc_num_wr;
    logic     rd_en;
    vc_mask_t vc_num_rd;
    flit_t    dout;
    vc_mask_t vc_not_empty;

    int errors;
    int checks;

    `include "vc_buffer_model.svh"

    vc_buffer dut (
        .clk          (clk),
        .reset        (reset),
        .din          (din),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .dout         (dout),
        .vc_not_empty (vc_not_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got %h expected %h at time %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic vc_mask_t vc_select(input int vc);
        vc_mask_t m;
        m = '0;
        if (vc >= 0) m[vc] = 1'b1; // -1 leaves the select idle
        return m;
    endfunction

    // one clock of stimulus whose check sees the effect of the previous op
    task automatic run_cycle(input logic wr, input int wvc, input logic rd, input int rvc,
                             input flit_t data);
        @(posedge clk);
        wr_en     <= wr;
        vc_num_wr <= vc_select(wvc);
        din       <= data;
        rd_en     <= rd;
        vc_num_rd <= vc_select(rvc);
        @(negedge clk);
        check_value("vc_not_empty", 64'(vc_not_empty), 64'(model_mask()));
        check_value("dout", 64'(dout), 64'(expect_dout));
        if (rd) expect_dout = model_q[rvc].pop_front(); // pop before push for the same vc
        if (wr) model_q[wvc].push_back(data);
    endtask

    // reset with flits still stored and dout loaded
    // every queue and the output register must clear
    task automatic reset_and_check();
        @(posedge clk);
        reset     <= 1'b1;
        wr_en     <= 1'b0;
        vc_num_wr <= '0;
        din       <= '0;
        rd_en     <= 1'b0;
        vc_num_rd <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int v = 0; v < `VC_NUM; v++) begin
            model_q[v].delete();
        end
        expect_dout = '0;
        @(negedge clk);
        check_value("vc_not_empty", 64'(vc_not_empty), 64'h0);
        check_value("dout", 64'(dout), 64'h0);
    endtask

    initial begin
        #(TIMEOUT);
        $display("timeout, the run did not finish within %0d time units", TIMEOUT);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int    wvc;
        int    rvc;
        logic  do_wr;
        logic  do_rd;

        errors      = 0;
        checks      = 0;
        rng_state   = SEED;
        expect_dout = '0;
        reset       = 1'b1;
        din         = '0;
        wr_en       = 1'b0;
        vc_num_wr   = '0;
        rd_en       = 1'b0;
        vc_num_rd   = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("vc_not_empty", 64'(vc_not_empty), 64'h0);
        check_value("dout", 64'(dout), 64'h0);

        // random mix of writes and reads on vc 0
        repeat (SINGLE_OPS) begin
            do_wr = (model_q[0].size() < `VC_DEPTH) && (rand_below(2) == 0);
            do_rd = (model_q[0].size() > 0) && (rand_below(2) == 0);
            run_cycle(do_wr, 0, do_rd, 0, random_flit());
        end
        while (model_q[0].size() > 0) run_cycle(1'b0, -1, 1'b1, 0, '0);

        // park one flit in every other vc and wrap the last slice
        for (int v = 0; v < WRAP_VC; v++) begin
            run_cycle(1'b1, v, 1'b0, -1, random_flit());
        end
        for (int r = 0; r < WRAP_ROUNDS; r++) begin
            for (int k = 0; k < `VC_DEPTH; k++) begin
                run_cycle(1'b1, WRAP_VC, 1'b0, -1, random_flit());
            end
            run_cycle(1'b0, -1, 1'b1, WRAP_VC, '0);
            repeat (3) run_cycle(1'b1, WRAP_VC, 1'b1, WRAP_VC, random_flit());
            while (model_q[WRAP_VC].size() > 0) begin
                run_cycle(1'b0, -1, 1'b1, WRAP_VC, '0);
            end
        end

        // interleaved traffic across all vcs
        repeat (RANDOM_OPS) begin
            wvc   = pick_open_vc();
            rvc   = pick_busy_vc();
            do_wr = (wvc >= 0) && (rand_below(4) != 0);
            do_rd = (rvc >= 0) && (rand_below(3) != 0);
            run_cycle(do_wr, wvc, do_rd, rvc, random_flit());
        end

        // drain and idle so the last read is checked
        rvc = pick_busy_vc();
        while (rvc >= 0) begin
            run_cycle(1'b0, -1, 1'b1, rvc, '0);
            rvc = pick_busy_vc();
        end
        repeat (2) run_cycle(1'b0, -1, 1'b0, -1, '0);

        // one flit per vc left stored across a reset
        for (int v = 0; v < `VC_NUM; v++) begin
            run_cycle(1'b1, v, 1'b0, -1, random_flit());
        end
        reset_and_check();

        // pointers restart together after the reset
        run_cycle(1'b1, 0, 1'b0, -1, random_flit());
        run_cycle(1'b0, -1, 1'b1, 0, '0);
        repeat (2) run_cycle(1'b0, -1, 1'b0, -1, '0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vc_buffer.f
+incdir+logic
+incdir+test
logic/buffer_pkg.sv
logic/flit_ram.sv
logic/vc_ptr_bank.sv
logic/vc_buffer.sv
test/vc_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vc buffer testbench with verilator
# exit status is nonzero when the run fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vc_buffer_sim
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
    -f vc_buffer.f \
    --top-module vc_buffer_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG_FILE"; then
    exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG_FILE"; then
    echo "no result line found in $LOG_FILE"
    exit 1
fi

exit 0
